//--- logic/vis_cfg_pkg.sv
package vis_cfg_pkg;

   // --------------------
   // array sizing
   // --------------------
   localparam int NANT_DEF  = 4;                              // antennas on the sample bus
   localparam int NPAIR_DEF = NANT_DEF * (NANT_DEF - 1) / 2;  // i<j pairs, 6 for 4 antennas
   localparam int WIDTH_DEF = 24;                             // accumulator == sram word
   localparam int ABITS_DEF = 3;                              // word address, covers NPAIR_DEF

   // --------------------
   // host side
   // --------------------
   // byte lanes per sram word, lanes above WIDTH_DEF read back as zero
   localparam int BYTES_PER_WORD = 4;

   // --------------------
   // integration
   // --------------------
   localparam int WINDOW_DEF = 32;  // samples per window, >= 4*NPAIR_DEF

endpackage

//--- logic/vis_bus_pkg.sv
package vis_bus_pkg;

   // prefetch fsm, one pair every READ -> WAIT_ACK -> WRITE
   typedef enum logic [2:0] {
      PF_IDLE     = 3'd0,  // out of reset, no window yet
      PF_READ     = 3'd1,  // stb to the correlator
      PF_WAIT_ACK = 3'd2,  // stb held, data taken on ack
      PF_WRITE    = 3'd3,  // word into sram port a
      PF_DONE     = 3'd4   // all pairs copied
   } pf_state_e;

   // host byte port
   typedef enum logic {
      HB_IDLE = 1'b0,
      HB_ACK  = 1'b1       // byte valid this cycle
   } hb_phase_e;

endpackage

//--- logic/corr_bank.sv
`timescale 1ns/1ps

module corr_bank
   import vis_cfg_pkg::*;
#(
   parameter int NANT   = NANT_DEF,
   parameter int NPAIR  = NPAIR_DEF,
   parameter int WIDTH  = WIDTH_DEF,
   parameter int ABITS  = ABITS_DEF,
   parameter int WINDOW = WINDOW_DEF
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             smp_valid_i,  // qualifies ant_i
   input  logic [NANT-1:0]  ant_i,        // 1-bit samples
   output logic             switching_o,  // pulse after the last sample of a window
   input  logic             cyc_i,
   input  logic             stb_i,
   input  logic [ABITS-1:0] adr_i,        // pair index
   output logic             ack_o,
   output logic [WIDTH-1:0] dat_o         // frozen bank count
);

   localparam int CBITS = $clog2(WINDOW);

   logic [WIDTH-1:0] acc [2][NPAIR];  // two banks of pair counters
   logic             sel;             // live bank, the other one is frozen
   logic [CBITS-1:0] smp_cnt;         // samples in the live window
   logic [NPAIR-1:0] agree;           // per pair, both bits equal
   logic             win_end;

   // --------------------
   // pair map
   // --------------------
   // lexicographic i<j order, (0,1) -> 0 ... (NANT-2,NANT-1) -> NPAIR-1
   for (genvar i = 0; i < NANT; i++) begin : g_ant_i
      for (genvar j = i + 1; j < NANT; j++) begin : g_ant_j
         localparam int P = i * NANT - i * (i + 1) / 2 + (j - i - 1);
         assign agree[P] = ~(ant_i[i] ^ ant_i[j]);  // xnor of the two samples
      end
   end

   assign win_end = smp_valid_i && (smp_cnt == CBITS'(WINDOW - 1));

   // --------------------
   // accumulate and swap
   // --------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sel         <= 1'b0;
         smp_cnt     <= '0;
         switching_o <= 1'b0;
         for (int b = 0; b < 2; b++) begin
            for (int p = 0; p < NPAIR; p++) begin
               acc[b][p] <= '0;
            end
         end
      end else begin
         switching_o <= win_end;  // lines up with the bank swap below
         if (smp_valid_i) begin
            smp_cnt <= win_end ? '0 : smp_cnt + 1'b1;
            for (int p = 0; p < NPAIR; p++) begin
               // last sample still lands in the bank that is about to freeze
               if (agree[p]) begin
                  acc[sel][p] <= acc[sel][p] + 1'b1;
               end
               if (win_end) begin
                  acc[!sel][p] <= '0;  // next live bank starts empty
               end
            end
            if (win_end) begin
               sel <= ~sel;
            end
         end
      end
   end

   // --------------------
   // read-only slave
   // --------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= cyc_i && stb_i && !ack_o;  // single ack, stb is held into it
      end
   end

   // data follows the address, valid by the ack cycle
   always_ff @(posedge clk_i) begin
      if (adr_i < NPAIR) begin
         dat_o <= acc[!sel][adr_i];
      end else begin
         dat_o <= '0;  // unused pair slots
      end
   end

   a_stb_in_cyc : assert property (@(posedge clk_i) disable iff (rst_i)
      stb_i |-> cyc_i);

endmodule

//--- logic/vis_prefetch.sv
`timescale 1ns/1ps

module vis_prefetch
   import vis_cfg_pkg::*;
   import vis_bus_pkg::*;
#(
   parameter int NPAIR = NPAIR_DEF,
   parameter int WIDTH = WIDTH_DEF,
   parameter int ABITS = ABITS_DEF
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             begin_i,     // bank swap restarts the copy
   output logic             ready_o,     // frozen window fully in sram
   output logic             a_cyc_o,     // master towards the correlator
   output logic             a_stb_o,
   output logic [ABITS-1:0] a_adr_o,
   input  logic             a_ack_i,
   input  logic [WIDTH-1:0] a_dat_i,
   output logic             b_we_o,      // sram port a without handshake
   output logic [ABITS-1:0] b_adr_o,
   output logic [WIDTH-1:0] b_dat_o,
   output logic [WIDTH-1:0] word_o,      // copy of each fetched word
   output logic             word_vld_o
);

   pf_state_e        state;
   logic [ABITS-1:0] adr_q;  // pair being copied
   logic [WIDTH-1:0] dat_q;  // word taken on ack
   logic             last;

   assign last = (adr_q == ABITS'(NPAIR - 1));

   // --------------------
   // fsm
   // --------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state <= PF_IDLE;
         adr_q <= '0;
      end else if (begin_i) begin  // a swap always restarts from pair 0
         state <= PF_READ;
         adr_q <= '0;
      end else begin
         case (state)
            PF_READ:     state <= PF_WAIT_ACK;
            PF_WAIT_ACK: begin
               if (a_ack_i) begin
                  state <= PF_WRITE;
               end
            end
            PF_WRITE:    begin
               if (last) begin
                  state <= PF_DONE;
               end else begin
                  state <= PF_READ;
                  adr_q <= adr_q + 1'b1;
               end
            end
            default:     state <= state;  // idle and done wait for begin_i
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state == PF_WAIT_ACK && a_ack_i) begin
         dat_q <= a_dat_i;
      end
   end

   // --------------------
   // outputs
   // --------------------
   assign a_cyc_o    = state inside {PF_READ, PF_WAIT_ACK, PF_WRITE};  // whole pair
   assign a_stb_o    = state inside {PF_READ, PF_WAIT_ACK};            // held up to ack
   assign a_adr_o    = adr_q;
   assign b_we_o     = (state == PF_WRITE);
   assign b_adr_o    = adr_q;
   assign b_dat_o    = dat_q;
   assign word_o     = dat_q;
   assign word_vld_o = (state == PF_WRITE);  // one pulse per word written
   assign ready_o    = (state == PF_DONE);

   a_no_write_idle : assert property (@(posedge clk_i) disable iff (rst_i)
      state == PF_IDLE |-> !b_we_o);

   a_not_ready_busy : assert property (@(posedge clk_i) disable iff (rst_i)
      a_cyc_o |-> !ready_o);

endmodule

//--- logic/vis_sram.sv
`timescale 1ns/1ps

module vis_sram
   import vis_cfg_pkg::*;
   import vis_bus_pkg::*;
#(
   parameter int NPAIR = NPAIR_DEF,
   parameter int WIDTH = WIDTH_DEF,
   parameter int ABITS = ABITS_DEF
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             a_we_i,   // word write from the prefetcher
   input  logic [ABITS-1:0] a_adr_i,
   input  logic [WIDTH-1:0] a_dat_i,
   input  logic             b_cyc_i,  // host byte reads
   input  logic             b_stb_i,
   input  logic [ABITS+1:0] b_adr_i,  // word*4 + lane
   output logic             b_ack_o,
   output logic [7:0]       b_dat_o
);

   logic [WIDTH-1:0]            mem [NPAIR];
   hb_phase_e                   phase;
   logic                        rd_req;
   logic [ABITS-1:0]            rd_wrd;
   logic [1:0]                  rd_lane;  // lsb first
   logic [8*BYTES_PER_WORD-1:0] rd_wide;  // word padded out to all lanes
   logic [7:0]                  byt_q;

   // --------------------
   // port a
   // --------------------
   always_ff @(posedge clk_i) begin
      if (a_we_i) begin
         mem[a_adr_i] <= a_dat_i;
      end
   end

   // --------------------
   // port b, host bytes
   // --------------------
   assign rd_req  = (phase == HB_IDLE) && b_cyc_i && b_stb_i;
   assign rd_wrd  = b_adr_i[ABITS+1:2];
   assign rd_lane = b_adr_i[1:0];

   always_comb begin
      rd_wide = '0;  // lanes past WIDTH and words past NPAIR stay zero
      if (rd_wrd < NPAIR) begin
         rd_wide[WIDTH-1:0] = mem[rd_wrd];
      end
   end

   // idle -> ack -> idle, a held stb starts the next read after the ack
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         phase <= HB_IDLE;
      end else if (rd_req) begin
         phase <= HB_ACK;
      end else begin
         phase <= HB_IDLE;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_req) begin
         byt_q <= rd_wide[8*rd_lane +: 8];
      end
   end

   assign b_ack_o = (phase == HB_ACK);
   assign b_dat_o = byt_q;

   a_ack_single : assert property (@(posedge clk_i) disable iff (rst_i)
      b_ack_o && b_stb_i |=> !b_ack_o);

endmodule

//--- logic/vis_fetch.sv
`timescale 1ns/1ps

module vis_fetch
   import vis_cfg_pkg::*;
#(
   parameter int NPAIR = NPAIR_DEF,
   parameter int WIDTH = WIDTH_DEF,
   parameter int ABITS = ABITS_DEF
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             switching_i,  // bank swap from the correlator
   output logic             available_o,  // window copied, sram readable
   output logic [WIDTH-1:0] checksum_o,   // xor of the window's words
   output logic             cor_cyc_o,
   output logic             cor_stb_o,
   output logic [ABITS-1:0] cor_adr_o,
   input  logic             cor_ack_i,
   input  logic [WIDTH-1:0] cor_dat_i,
   input  logic             cyc_i,        // host byte port
   input  logic             stb_i,
   input  logic [ABITS+1:0] adr_i,
   output logic             ack_o,
   output logic [7:0]       byt_o
);

   logic             pf_we;
   logic [ABITS-1:0] pf_adr;
   logic [WIDTH-1:0] pf_dat;
   logic [WIDTH-1:0] word;
   logic             word_vld;

   // --------------------
   // checksum
   // --------------------
   // last xor lands on the same edge that raises available_o
   always_ff @(posedge clk_i) begin
      if (rst_i || switching_i) begin
         checksum_o <= '0;  // new window
      end else if (word_vld) begin
         checksum_o <= checksum_o ^ word;
      end
   end

   vis_prefetch #(
      .NPAIR (NPAIR),
      .WIDTH (WIDTH),
      .ABITS (ABITS)
   ) u_prefetch (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .begin_i    (switching_i),
      .ready_o    (available_o),
      .a_cyc_o    (cor_cyc_o),   // correlator side
      .a_stb_o    (cor_stb_o),
      .a_adr_o    (cor_adr_o),
      .a_ack_i    (cor_ack_i),
      .a_dat_i    (cor_dat_i),
      .b_we_o     (pf_we),       // sram side
      .b_adr_o    (pf_adr),
      .b_dat_o    (pf_dat),
      .word_o     (word),
      .word_vld_o (word_vld)
   );

   vis_sram #(
      .NPAIR (NPAIR),
      .WIDTH (WIDTH),
      .ABITS (ABITS)
   ) u_sram (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .a_we_i  (pf_we),
      .a_adr_i (pf_adr),
      .a_dat_i (pf_dat),
      .b_cyc_i (cyc_i),
      .b_stb_i (stb_i),
      .b_adr_i (adr_i),
      .b_ack_o (ack_o),
      .b_dat_o (byt_o)
   );

endmodule

//--- logic/vis_top.sv
`timescale 1ns/1ps

module vis_top
   import vis_cfg_pkg::*;
#(
   parameter int NANT   = NANT_DEF,
   parameter int NPAIR  = NPAIR_DEF,
   parameter int WIDTH  = WIDTH_DEF,
   parameter int ABITS  = ABITS_DEF,
   parameter int WINDOW = WINDOW_DEF
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             smp_valid_i,
   input  logic [NANT-1:0]  ant_i,
   input  logic             cyc_i,        // host byte reads
   input  logic             stb_i,
   input  logic [ABITS+1:0] adr_i,
   output logic             ack_o,
   output logic [7:0]       byt_o,
   output logic             available_o,
   output logic [WIDTH-1:0] checksum_o
);

   // correlator bus and swap strobe
   logic             switching;
   logic             cor_cyc;
   logic             cor_stb;
   logic [ABITS-1:0] cor_adr;
   logic             cor_ack;
   logic [WIDTH-1:0] cor_dat;

   corr_bank #(
      .NANT   (NANT),
      .NPAIR  (NPAIR),
      .WIDTH  (WIDTH),
      .ABITS  (ABITS),
      .WINDOW (WINDOW)
   ) u_corr_bank (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .smp_valid_i (smp_valid_i),
      .ant_i       (ant_i),
      .switching_o (switching),
      .cyc_i       (cor_cyc),
      .stb_i       (cor_stb),
      .adr_i       (cor_adr),
      .ack_o       (cor_ack),
      .dat_o       (cor_dat)
   );

   vis_fetch #(
      .NPAIR (NPAIR),
      .WIDTH (WIDTH),
      .ABITS (ABITS)
   ) u_vis_fetch (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .switching_i (switching),
      .available_o (available_o),
      .checksum_o  (checksum_o),
      .cor_cyc_o   (cor_cyc),
      .cor_stb_o   (cor_stb),
      .cor_adr_o   (cor_adr),
      .cor_ack_i   (cor_ack),
      .cor_dat_i   (cor_dat),
      .cyc_i       (cyc_i),
      .stb_i       (stb_i),
      .adr_i       (adr_i),
      .ack_o       (ack_o),
      .byt_o       (byt_o)
   );

endmodule

//--- tb/tb_vis_top.sv
`timescale 1ns/1ps

module tb_vis_top
   import vis_cfg_pkg::*;
();

   localparam int NANT   = NANT_DEF;
   localparam int NPAIR  = NPAIR_DEF;
   localparam int WIDTH  = WIDTH_DEF;
   localparam int ABITS  = ABITS_DEF;
   localparam int WINDOW = WINDOW_DEF;
   localparam int NWIN   = 4;  // random, random, all agree, random
   // worst case per window with gapped samples, the copy and 3 cycles per byte read
   localparam int WIN_CYC    = 2 * WINDOW + 3 * NPAIR + 1 + 3 * BYTES_PER_WORD * NPAIR + 8;
   localparam int TIMEOUT_NS = (NWIN * WIN_CYC + 50) * 8;

   logic             clk_i;
   logic             rst_i;
   logic             smp_valid_i;
   logic [NANT-1:0]  ant_i;
   logic             cyc_i;
   logic             stb_i;
   logic [ABITS+1:0] adr_i;
   logic             ack_o;
   logic [7:0]       byt_o;
   logic             available_o;
   logic [WIDTH-1:0] checksum_o;

   int               live_cnt [NPAIR];  // reference counts of the window in progress
   int               frz_cnt [NPAIR];   // counts of the window being read back
   logic [WIDTH-1:0] exp_xor;           // reference checksum
   logic [7:0]       exp_byte;          // byte expected on the next ack
   logic             all_agree;         // window with identical antenna bits
   string            test_name;
   int               errors;

   vis_top #(
      .NANT   (NANT),
      .NPAIR  (NPAIR),
      .WIDTH  (WIDTH),
      .ABITS  (ABITS),
      .WINDOW (WINDOW)
   ) u_vis_top (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .smp_valid_i (smp_valid_i),
      .ant_i       (ant_i),
      .cyc_i       (cyc_i),
      .stb_i       (stb_i),
      .adr_i       (adr_i),
      .ack_o       (ack_o),
      .byt_o       (byt_o),
      .available_o (available_o),
      .checksum_o  (checksum_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;  // 8 ns period
   end

   // --------------------
   // checks
   // --------------------
   a_reset_state : assert property (@(posedge clk_i)
      $fell(rst_i) |-> !available_o && !ack_o && checksum_o == '0)
      else begin
         errors++;
         $display("outputs not cleared by reset");
      end

   a_byte : assert property (@(posedge clk_i) disable iff (rst_i)
      ack_o |-> byt_o == exp_byte)
      else begin
         errors++;
         $display("ERR %s: expected %02h, actual %02h", test_name, $sampled(exp_byte),
                  $sampled(byt_o));
      end

   a_checksum : assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(available_o) |-> checksum_o == exp_xor)
      else begin
         errors++;
         $display("ERR %s checksum: expected %06h, actual %06h", test_name,
                  $sampled(exp_xor), $sampled(checksum_o));
      end

   // top lane is beyond the 24-bit word
   a_lane3_zero : assert property (@(posedge clk_i) disable iff (rst_i)
      cyc_i && stb_i && adr_i[1:0] == 2'd3 |=> byt_o == 8'h00)
      else begin
         errors++;
         $display("ERR %s lane3: expected 00, actual %02h", test_name, $sampled(byt_o));
      end

   a_agree_full : assert property (@(posedge clk_i) disable iff (rst_i)
      all_agree && cyc_i && stb_i && adr_i[1:0] == 2'd0 |=> byt_o == 8'(WINDOW))
      else begin
         errors++;
         $display("ERR %s full count: expected %02h, actual %02h", test_name,
                  8'(WINDOW), $sampled(byt_o));
      end

   a_ack_delay : assert property (@(posedge clk_i) disable iff (rst_i)
      cyc_i && stb_i |=> ack_o)
      else begin
         errors++;
         $display("host read was not acked one cycle after its strobe");
      end

   a_ack_cause : assert property (@(posedge clk_i) disable iff (rst_i)
      ack_o |-> $past(cyc_i && stb_i))
      else begin
         errors++;
         $display("host ack came without a strobe in the cycle before");
      end

   // --------------------
   // reference model
   // --------------------
   // one slot per i<j pair in lexicographic order
   task automatic count_pairs(input logic [NANT-1:0] smp);
      int p;
      p = 0;
      for (int i = 0; i < NANT; i++) begin
         for (int j = i + 1; j < NANT; j++) begin
            if (smp[i] == smp[j]) begin
               live_cnt[p]++;
            end
            p++;
         end
      end
   endtask

   task automatic run_window(input logic agree);
      logic [NANT-1:0] smp;
      int              n;
      n = 0;
      for (int p = 0; p < NPAIR; p++) begin
         live_cnt[p] = 0;  // every window counts from zero
      end
      while (n < WINDOW) begin
         @(posedge clk_i);
         if ($urandom % 4 == 0) begin
            smp_valid_i <= 1'b0;  // idle gap
         end else begin
            if (agree) begin
               smp = ($urandom % 2) ? '1 : '0;
            end else begin
               smp = NANT'($urandom);
            end
            smp_valid_i <= 1'b1;
            ant_i       <= smp;
            count_pairs(smp);
            n++;
         end
      end
      @(posedge clk_i);
      smp_valid_i <= 1'b0;
      exp_xor = '0;
      for (int p = 0; p < NPAIR; p++) begin
         frz_cnt[p] = live_cnt[p];
         exp_xor    = exp_xor ^ WIDTH'(live_cnt[p]);
      end
   endtask

   // available drops after the swap, then rises when the copy is done
   task automatic wait_available();
      @(posedge clk_i);
      while (available_o) begin
         @(posedge clk_i);
      end
      while (!available_o) begin
         @(posedge clk_i);
      end
   endtask

   task automatic host_read(input int adr, input logic [7:0] exp);
      @(posedge clk_i);
      cyc_i    <= 1'b1;
      stb_i    <= 1'b1;
      adr_i    <= (ABITS+2)'(adr);
      exp_byte <= exp;
      @(posedge clk_i);
      stb_i <= 1'b0;  // dropped in the ack cycle
      @(posedge clk_i);
      cyc_i <= 1'b0;
   endtask

   task automatic read_window();
      for (int w = 0; w < NPAIR; w++) begin
         for (int b = 0; b < BYTES_PER_WORD; b++) begin
            host_read(w * BYTES_PER_WORD + b, 8'(frz_cnt[w] >> (8 * b)));  // lsb first
         end
      end
   endtask

   // --------------------
   // stimulus
   // --------------------
   initial begin
      void'($urandom(32'h92b3));
      rst_i        = 1'b1;
      smp_valid_i  = 1'b0;
      ant_i        = '0;
      cyc_i        = 1'b0;
      stb_i        = 1'b0;
      adr_i        = '0;
      exp_byte     = '0;
      exp_xor      = '0;
      all_agree    = 1'b0;
      errors       = 0;
      test_name    = "reset";
      repeat (3) @(posedge clk_i);
      rst_i <= 1'b0;
      for (int k = 0; k < NWIN; k++) begin
         all_agree = (k == 2);
         test_name = all_agree ? "all_agree" : $sformatf("window%0d", k);
         run_window(all_agree);
         wait_available();
         read_window();
      end
      all_agree = 1'b0;
      repeat (2) @(posedge clk_i);
      $display("checks done, errors: %0d", errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("timeout: the run did not finish within %0d ns, errors: %0d", TIMEOUT_NS, errors);
      $display("** FAIL **");
      $finish;
   end

endmodule

//--- build.f
logic/vis_cfg_pkg.sv
logic/vis_bus_pkg.sv
logic/corr_bank.sv
logic/vis_prefetch.sv
logic/vis_sram.sv
logic/vis_fetch.sv
logic/vis_top.sv
tb/tb_vis_top.sv

//--- Bender.yml
package:
  name: vis_fetch

sources:
  - logic/vis_cfg_pkg.sv
  - logic/vis_bus_pkg.sv
  - logic/corr_bank.sv
  - logic/vis_prefetch.sv
  - logic/vis_sram.sv
  - logic/vis_fetch.sv
  - logic/vis_top.sv
  - target: test
    files:
      - tb/tb_vis_top.sv
